// ==== ps2Pkg.sv ====
package ps2Pkg;

	// Frame on the wire is start, eight data bits LSB first, parity, stop
	localparam int frameBits = 11;
	localparam int startPos = 0;
	localparam int dataLow = 1; // First data bit in the frame
	localparam int parityPos = 9;
	localparam int stopPos = 10;

	localparam int indexWidth = $clog2(frameBits);
	localparam logic [indexWidth-1:0] lastBitIndex = indexWidth'(frameBits - 1);

	localparam int frameTimeout = 2000; // Idle clk cycles before a partial frame is dropped
	localparam int timeoutWidth = $clog2(frameTimeout);
	localparam logic [timeoutWidth-1:0] timeoutLast = timeoutWidth'(frameTimeout - 1);

	localparam logic [7:0] extendCode = 8'hE0; // Extended key prefix
	localparam logic [7:0] releaseCode = 8'hF0; // Break prefix
	localparam logic [7:0] noPrefix = 8'h00;

	// A 16-bit key word written as bytes and shown as hex digits
	typedef union packed
	{
		struct packed
		{
			logic [7:0] prefix;
			logic [7:0] code;
		} fields;
		logic [0:3][3:0] nibbles; // Element 0 is the most significant digit
	} keyWord;

endpackage

// ==== displayPkg.sv ====
package displayPkg;

	// Segment order is gfedcba and a lit segment is driven low
	localparam int segWidth = 7;

	typedef logic [segWidth-1:0] segPattern;

	localparam int digitCount = 4; // Digits on the board

	localparam segPattern segBlank = '1; // All segments off

endpackage

// ==== ps2Receiver.sv ====
`timescale 1ns/1ps

module ps2Receiver (
	input logic clk,
	input logic rst,
	input logic keyClk,
	input logic keyData,
	output logic [7:0] scanByte,
	output logic byteValid,
	output logic frameError
);

	logic [2:0] keyClkSync; // Two sync stages and one more for the edge
	logic [1:0] keyDataSync;
	logic clkFall;
	logic [ps2Pkg::indexWidth-1:0] bitIndex;
	logic [ps2Pkg::timeoutWidth-1:0] idleCount;
	logic [ps2Pkg::frameBits-1:0] frameReg;
	logic frameFull;
	logic startOk;
	logic stopOk;
	logic parityOk;
	logic frameOk;

	// Both PS/2 lines come from the keyboard with no relation to clk
	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			keyClkSync <= 3'b111; // Bus idles high
			keyDataSync <= 2'b11;
		end
		else
		begin
			keyClkSync <= {keyClkSync[1:0], keyClk};
			keyDataSync <= {keyDataSync[0], keyData};
		end
	end

	assign clkFall = keyClkSync[2] & ~keyClkSync[1]; // High one cycle per falling edge

	// Bit position in the frame and the idle watchdog
	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			bitIndex <= '0;
			idleCount <= '0;
			frameFull <= 1'b0;
		end
		else
		begin
			frameFull <= 1'b0;
			if (clkFall)
			begin
				idleCount <= '0;
				if (bitIndex == ps2Pkg::lastBitIndex)
				begin
					bitIndex <= '0;
					frameFull <= 1'b1; // Eleventh bit just shifted in
				end
				else
					bitIndex <= bitIndex + 1'b1;
			end
			else if (bitIndex != '0)
			begin
				if (idleCount == ps2Pkg::timeoutLast)
				begin
					bitIndex <= '0; // Keyboard stalled mid frame
					idleCount <= '0;
				end
				else
					idleCount <= idleCount + 1'b1;
			end
		end
	end

	// Bits enter at the top so the start bit ends up in bit 0
	always_ff @(posedge clk)
	begin
		if (clkFall)
			frameReg <= {keyDataSync[1], frameReg[ps2Pkg::frameBits-1:1]};
	end

	assign startOk = (frameReg[ps2Pkg::startPos] == 1'b0);
	assign stopOk = (frameReg[ps2Pkg::stopPos] == 1'b1);
	assign parityOk = ^frameReg[ps2Pkg::parityPos:ps2Pkg::dataLow]; // Odd over data and parity
	assign frameOk = startOk & stopOk & parityOk;

	// Exactly one of the two strobes follows a complete frame
	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			byteValid <= 1'b0;
			frameError <= 1'b0;
		end
		else
		begin
			byteValid <= frameFull & frameOk;
			frameError <= frameFull & ~frameOk;
		end
	end

	// Register holds still until the next falling edge long after the strobe
	assign scanByte = frameReg[ps2Pkg::dataLow +: 8];

endmodule

// ==== scanCodeTracker.sv ====
`timescale 1ns/1ps

module scanCodeTracker (
	input logic clk,
	input logic rst,
	input logic [7:0] scanByte,
	input logic byteValid,
	output ps2Pkg::keyWord keyCode,
	output logic keyHeld
);

	logic extendFlag;
	logic releaseFlag;
	logic isExtend;
	logic isRelease;
	logic [7:0] prefixByte;
	logic [7:0] heldCode; // Code byte of the last key pressed

	assign isExtend = (scanByte == ps2Pkg::extendCode);
	assign isRelease = (scanByte == ps2Pkg::releaseCode);

	// Break outranks extended when both prefixes came in
	always_comb
	begin
		if (releaseFlag)
			prefixByte = ps2Pkg::releaseCode;
		else if (extendFlag)
			prefixByte = ps2Pkg::extendCode;
		else
			prefixByte = ps2Pkg::noPrefix;
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			extendFlag <= 1'b0;
			releaseFlag <= 1'b0;
			keyCode <= '0;
			keyHeld <= 1'b0;
			heldCode <= '0;
		end
		else if (byteValid)
		begin
			if (isExtend)
				extendFlag <= 1'b1; // Word waits for the code byte
			else if (isRelease)
				releaseFlag <= 1'b1;
			else
			begin
				extendFlag <= 1'b0;
				releaseFlag <= 1'b0;
				keyCode.fields.prefix <= prefixByte;
				keyCode.fields.code <= scanByte;
				if (!releaseFlag)
				begin
					keyHeld <= 1'b1; // Make code
					heldCode <= scanByte;
				end
				else if (scanByte == heldCode)
					keyHeld <= 1'b0; // Held key let go
			end
		end
	end

endmodule

// ==== hexTo7Seg.sv ====
`timescale 1ns/1ps

module hexTo7Seg (
	input logic [3:0] x,
	output displayPkg::segPattern z
);

	// Patterns are written lit high and inverted for the common anode digits
	always_comb
	begin
		case (x)
			4'h0: z = ~7'b0111111;
			4'h1: z = ~7'b0000110;
			4'h2: z = ~7'b1011011;
			4'h3: z = ~7'b1001111;
			4'h4: z = ~7'b1100110;
			4'h5: z = ~7'b1101101;
			4'h6: z = ~7'b1111101;
			4'h7: z = ~7'b0000111;
			4'h8: z = ~7'b1111111;
			4'h9: z = ~7'b1100111;
			4'hA: z = ~7'b1110111; // Upper case A
			4'hB: z = ~7'b1111100; // Lower case b
			4'hC: z = ~7'b1011000; // Lower case c
			4'hD: z = ~7'b1011110; // Lower case d
			4'hE: z = ~7'b1111001;
			4'hF: z = ~7'b1110001;
			default: z = displayPkg::segBlank;
		endcase
	end

endmodule

// ==== keyboardDisplayTop.sv ====
`timescale 1ns/1ps

module keyboardDisplayTop (
	input logic clk,
	input logic rst,
	input logic keyClk,
	input logic keyData,
	output displayPkg::segPattern out1A,
	output displayPkg::segPattern out2A,
	output displayPkg::segPattern out3A,
	output displayPkg::segPattern out4A,
	output logic keyHeld,
	output logic frameError
);

	logic [7:0] scanByte;
	logic byteValid;
	ps2Pkg::keyWord keyCode;
	displayPkg::segPattern digitSeg [displayPkg::digitCount]; // Index 0 is the leftmost digit

	ps2Receiver receiver (
		.clk(clk),
		.rst(rst),
		.keyClk(keyClk),
		.keyData(keyData),
		.scanByte(scanByte),
		.byteValid(byteValid),
		.frameError(frameError)
	);

	scanCodeTracker tracker (
		.clk(clk),
		.rst(rst),
		.scanByte(scanByte),
		.byteValid(byteValid),
		.keyCode(keyCode),
		.keyHeld(keyHeld)
	);

	// One decoder per hex digit of the key word
	for (genvar i = 0; i < displayPkg::digitCount; i++)
	begin : gDigit
		hexTo7Seg seg (
			.x(keyCode.nibbles[i]),
			.z(digitSeg[i])
		);
	end

	assign out1A = digitSeg[0]; // Prefix high nibble
	assign out2A = digitSeg[1];
	assign out3A = digitSeg[2];
	assign out4A = digitSeg[3]; // Code low nibble

endmodule

// ==== tbClockGen.sv ====
`timescale 1ns/1ps

module tbClockGen (
	output logic clk,
	output logic rst
);

	localparam int resetCycles = 16;

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period
	end

	initial
	begin
		rst = 1'b0; // Active low and held from time zero
		repeat (resetCycles) @(posedge clk);
		#1 rst = 1'b1;
	end

endmodule

// ==== keyboardDisplayTb_checker.sv ====
`timescale 1ns/1ps

module keyboardDisplayTb_checker (
	input logic clk,
	input logic rst,
	input logic byteValid,
	input logic frameError
);

	// A frame ends either good or bad but never both
	strobesExclusive: assert property (@(posedge clk) disable iff (!rst)
		!(byteValid && frameError))
		else $error("byteValid and frameError high in the same cycle");

	validSingleCycle: assert property (@(posedge clk) disable iff (!rst)
		byteValid |=> !byteValid)
		else $error("byteValid held longer than one cycle");

	errorSingleCycle: assert property (@(posedge clk) disable iff (!rst)
		frameError |=> !frameError)
		else $error("frameError held longer than one cycle");

	// Strobes settle to zero one edge into reset
	quietInReset: assert property (@(posedge clk)
		!rst |=> (!byteValid && !frameError))
		else $error("strobe seen while reset is asserted");

endmodule

// ==== keyboardDisplayTb.sv ====
`timescale 1ns/1ps

module keyboardDisplayTb;

	localparam int halfPeriod = 20; // keyClk half period in clk cycles
	localparam int settleCycles = 8;
	localparam int idleGap = 20;
	localparam int rowCount = 11;
	localparam int timeoutLimit =
		rowCount * (22 * halfPeriod + 50) + ps2Pkg::frameTimeout + 500;

	typedef struct packed
	{
		logic [7:0] sendByte;
		logic badParity;
		logic [3:0] bitCount; // Less than a full frame means truncated
		logic [15:0] expWord;
		logic expHeld;
		logic expError;
	} frameRow;

	logic clk;
	logic rst;
	logic keyClk;
	logic keyData;
	displayPkg::segPattern out1A;
	displayPkg::segPattern out2A;
	displayPkg::segPattern out3A;
	displayPkg::segPattern out4A;
	logic keyHeld;
	logic frameError;
	frameRow rows [rowCount];
	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;
	int errorPulses = 0;
	int validPulses = 0;

	tbClockGen clockGen (
		.clk(clk),
		.rst(rst)
	);

	keyboardDisplayTop i_dut (
		.clk(clk),
		.rst(rst),
		.keyClk(keyClk),
		.keyData(keyData),
		.out1A(out1A),
		.out2A(out2A),
		.out3A(out3A),
		.out4A(out4A),
		.keyHeld(keyHeld),
		.frameError(frameError)
	);

	bind ps2Receiver keyboardDisplayTb_checker rxChecker (
		.clk(clk),
		.rst(rst),
		.byteValid(byteValid),
		.frameError(frameError)
	);

	// Count the pulses of both receiver strobes
	always @(posedge clk)
	begin
		if (frameError)
			errorPulses <= errorPulses + 1;
		if (i_dut.receiver.byteValid)
			validPulses <= validPulses + 1;
	end

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount == timeoutLimit)
		begin
			$display("Timeout: run did not finish within %0d clk cycles", timeoutLimit);
			$display("Test failures found");
			$finish;
		end
	end

	// Active-low gfedcba for common anode digits
	function automatic displayPkg::segPattern segFor(input logic [3:0] nibble);
		case (nibble)
			4'h0: segFor = 7'h40;
			4'h1: segFor = 7'h79;
			4'h2: segFor = 7'h24;
			4'h3: segFor = 7'h30;
			4'h4: segFor = 7'h19;
			4'h5: segFor = 7'h12;
			4'h6: segFor = 7'h02;
			4'h7: segFor = 7'h78;
			4'h8: segFor = 7'h00;
			4'h9: segFor = 7'h18;
			4'hA: segFor = 7'h08;
			4'hB: segFor = 7'h03;
			4'hC: segFor = 7'h27;
			4'hD: segFor = 7'h21;
			4'hE: segFor = 7'h06;
			default: segFor = 7'h0E; // F
		endcase
	endfunction

	task automatic checkValue(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		checkCount++;
		if (actual !== expected)
		begin
			$display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic tick(input int n);
		repeat (n) @(posedge clk);
		#1; // Inputs move just after the edge
	endtask

	task automatic checkDisplay(input logic [15:0] word);
		checkValue("out1A", 16'(segFor(word[15:12])), 16'(out1A));
		checkValue("out2A", 16'(segFor(word[11:8])), 16'(out2A));
		checkValue("out3A", 16'(segFor(word[7:4])), 16'(out3A));
		checkValue("out4A", 16'(segFor(word[3:0])), 16'(out4A));
	endtask

	// Returns right after the last falling edge with keyClk still low
	task automatic sendFrame(input logic [7:0] data, input logic badParity,
		input int bitCount);
		logic [ps2Pkg::frameBits-1:0] frame;
		frame = {1'b1, ~^data ^ badParity, data, 1'b0}; // Stop, odd parity, data, start
		for (int i = 0; i < bitCount; i++)
		begin
			keyData = frame[i]; // Changes while keyClk is high
			tick(halfPeriod);
			keyClk = 1'b0;
			if (i < bitCount - 1)
			begin
				tick(halfPeriod);
				keyClk = 1'b1;
			end
		end
	endtask

	task automatic releaseBus(input int gap);
		tick(halfPeriod - settleCycles);
		keyClk = 1'b1;
		keyData = 1'b1;
		tick(gap);
	endtask

	task automatic fillTable();
		rows[0] = '{8'h1C, 1'b0, 4'd11, 16'h001C, 1'b1, 1'b0}; // Plain make code
		rows[1] = '{8'hF0, 1'b0, 4'd11, 16'h001C, 1'b1, 1'b0};
		rows[2] = '{8'h1C, 1'b0, 4'd11, 16'hF01C, 1'b0, 1'b0}; // Break of the held key
		rows[3] = '{8'hE0, 1'b0, 4'd11, 16'hF01C, 1'b0, 1'b0};
		rows[4] = '{8'h75, 1'b0, 4'd11, 16'hE075, 1'b1, 1'b0};
		rows[5] = '{8'hE0, 1'b0, 4'd11, 16'hE075, 1'b1, 1'b0};
		rows[6] = '{8'hF0, 1'b0, 4'd11, 16'hE075, 1'b1, 1'b0};
		rows[7] = '{8'h75, 1'b0, 4'd11, 16'hF075, 1'b0, 1'b0}; // Extended break
		rows[8] = '{8'h1C, 1'b1, 4'd11, 16'hF075, 1'b0, 1'b1}; // Bad parity
		rows[9] = '{8'h2A, 1'b0, 4'd5, 16'hF075, 1'b0, 1'b0}; // Stalls after 5 bits
		rows[10] = '{8'h2A, 1'b0, 4'd11, 16'h002A, 1'b1, 1'b0};
	endtask

	initial
	begin
		int errorsBefore;
		int validsBefore;
		logic expValid;
		keyClk = 1'b1; // Idle bus
		keyData = 1'b1;
		fillTable();
		wait (rst === 1'b1);
		tick(2);
		checkDisplay(16'h0000);
		checkValue("keyHeld", 16'(1'b0), 16'(keyHeld));
		checkValue("frameError pulses", 16'd0, 16'(errorPulses));
		for (int r = 0; r < rowCount; r++)
		begin
			errorsBefore = errorPulses;
			validsBefore = validPulses;
			expValid = !rows[r].expError && (int'(rows[r].bitCount) == ps2Pkg::frameBits);
			sendFrame(rows[r].sendByte, rows[r].badParity, int'(rows[r].bitCount));
			tick(settleCycles);
			checkDisplay(rows[r].expWord);
			checkValue("keyHeld", 16'(rows[r].expHeld), 16'(keyHeld));
			if (int'(rows[r].bitCount) < ps2Pkg::frameBits)
				releaseBus(idleGap + ps2Pkg::frameTimeout); // Let the receiver drop it
			else
				releaseBus(idleGap);
			checkValue("frameError pulses", 16'(rows[r].expError),
				16'(errorPulses - errorsBefore));
			checkValue("byteValid pulses", 16'(expValid), 16'(validPulses - validsBefore));
		end
		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== list.f ====
ps2Pkg.sv
displayPkg.sv
ps2Receiver.sv
scanCodeTracker.sv
hexTo7Seg.sv
keyboardDisplayTop.sv
tbClockGen.sv
keyboardDisplayTb_checker.sv
keyboardDisplayTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module keyboardDisplayTb -f list.f -o simv

if ! ./obj_dir/simv > sim.log 2>&1; then
	cat sim.log
	echo "Simulation exited with an error status"
	exit 1
fi
cat sim.log

if grep -q "Test failures found" sim.log; then
	exit 1
fi
exit 0
